// ==== include/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// hart constants
//////////////////////////////////////////////////////////////////////

// first fetch address.
`define RESET_PC    32'h0000_0000

// every trap lands here.
`define TRAP_VECTOR 32'h0000_0000

// x1 to x31 since x0 is hardwired.
`define NREGS       31

`endif

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// major opcodes of the supported subset
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// fixed instruction fields, msb first
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [6:0] funct7;  // also imm[11:5] for i/s types.
		logic [4:0] rs2;     // shamt for shift immediates.
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} insn_fields_t;

endpackage

// ==== design/rv_step_pkg.sv ====
`include "rv_settings.svh"

package rv_step_pkg;

	// x[1] holds x1 and x0 is not stored.
	typedef struct packed {
		logic [`NREGS:1][31:0] x;
	} reg_state_t;

	// word aligned addr with the masks selecting byte lanes.
	typedef struct packed {
		logic [3:0]  rmask;
		logic [3:0]  wmask;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] pc;
		reg_state_t  regs;
		mem_req_t    mem;
		logic        excep;
	} step_out_t;

	// effect of one instruction as the formal model states it.
	typedef struct packed {
		logic        valid;
		logic        trap;
		logic [4:0]  rs1_addr;
		logic [4:0]  rs2_addr;
		logic [4:0]  rd_addr;
		logic [31:0] rd_wdata;
		logic [31:0] pc_wdata;
		logic [31:0] mem_addr;
		logic [3:0]  mem_rmask;
		logic [3:0]  mem_wmask;
		logic [31:0] mem_wdata;
	} spec_t;

endpackage

// ==== design/rv_decode.sv ====
module rv_decode
	import rv_step_pkg::*;
(
	input  logic [31:0] insn,
	input  logic [31:0] pc,
	input  logic [31:0] rdata,
	input  logic [31:0] rs1_rdata,
	input  logic [31:0] rs2_rdata,
	output spec_t       spec
);
	logic [16:0] key;
	logic [6:0]  opc;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        is_load;
	logic        is_store;
	logic        is_branch;
	logic        use_rs1;
	logic        use_rs2;
	logic        use_rd;
	logic [31:0] addr;
	logic [1:0]  lane;
	logic [7:0]  byte_in;
	logic        word;
	logic        ill;
	logic        taken;
	logic [31:0] rd_val;
	logic [31:0] st_data;
	logic [31:0] next_pc;
	logic        trap;

	assign key = {insn[31:25], insn[14:12], insn[6:0]};  // funct7, funct3, opcode.
	assign opc = insn[6:0];

	assign imm_i = {{21{insn[31]}}, insn[30:20]};
	assign imm_s = {{21{insn[31]}}, insn[30:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'h000};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	assign is_load   = (opc == 7'b0000011);
	assign is_store  = (opc == 7'b0100011);
	assign is_branch = (opc == 7'b1100011);
	assign use_rs1   = !(opc == 7'b0110111 || opc == 7'b0010111 || opc == 7'b1101111);
	assign use_rs2   = is_branch || is_store || opc == 7'b0110011;
	assign use_rd    = !(is_branch || is_store);

	assign addr    = rs1_rdata + (is_store ? imm_s : imm_i);
	assign lane    = addr[1:0];
	assign byte_in = rdata[8 * lane +: 8];
	assign word    = insn[13];  // lw and sw.

	//////////////////////////////////////////////////////////////////////
	// one row per instruction
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ill     = 1'b0;
		taken   = 1'b0;
		rd_val  = '0;
		st_data = '0;
		casez (key)
			17'b???????_???_0110111: rd_val = imm_u;                                 // lui.
			17'b???????_???_0010111: rd_val = pc + imm_u;                            // auipc.
			17'b???????_???_1101111: rd_val = pc + 32'd4;                            // jal.
			17'b???????_000_1100111: rd_val = pc + 32'd4;                            // jalr.
			17'b???????_000_1100011: taken = (rs1_rdata == rs2_rdata);
			17'b???????_001_1100011: taken = (rs1_rdata != rs2_rdata);
			17'b???????_100_1100011: taken = ($signed(rs1_rdata) < $signed(rs2_rdata));
			17'b???????_101_1100011: taken = ($signed(rs1_rdata) >= $signed(rs2_rdata));
			17'b???????_110_1100011: taken = (rs1_rdata < rs2_rdata);
			17'b???????_111_1100011: taken = (rs1_rdata >= rs2_rdata);
			17'b???????_000_0000011: rd_val = {{24{byte_in[7]}}, byte_in};          // lb.
			17'b???????_100_0000011: rd_val = {24'd0, byte_in};                     // lbu.
			17'b???????_010_0000011: rd_val = rdata;                                // lw.
			17'b???????_000_0100011: st_data = rs2_rdata << (8 * lane);             // sb.
			17'b???????_010_0100011: st_data = rs2_rdata;                           // sw.
			17'b???????_000_0010011: rd_val = rs1_rdata + imm_i;
			17'b???????_010_0010011: rd_val = {31'd0, $signed(rs1_rdata) < $signed(imm_i)};
			17'b???????_011_0010011: rd_val = {31'd0, rs1_rdata < imm_i};
			17'b???????_100_0010011: rd_val = rs1_rdata ^ imm_i;
			17'b???????_110_0010011: rd_val = rs1_rdata | imm_i;
			17'b???????_111_0010011: rd_val = rs1_rdata & imm_i;
			17'b0000000_001_0010011: rd_val = rs1_rdata << insn[24:20];
			17'b0000000_101_0010011: rd_val = rs1_rdata >> insn[24:20];
			17'b0100000_101_0010011: rd_val = $signed(rs1_rdata) >>> insn[24:20];
			17'b0000000_000_0110011: rd_val = rs1_rdata + rs2_rdata;
			17'b0100000_000_0110011: rd_val = rs1_rdata - rs2_rdata;
			17'b0000000_001_0110011: rd_val = rs1_rdata << rs2_rdata[4:0];
			17'b0000000_010_0110011: rd_val = {31'd0, $signed(rs1_rdata) < $signed(rs2_rdata)};
			17'b0000000_011_0110011: rd_val = {31'd0, rs1_rdata < rs2_rdata};
			17'b0000000_100_0110011: rd_val = rs1_rdata ^ rs2_rdata;
			17'b0000000_101_0110011: rd_val = rs1_rdata >> rs2_rdata[4:0];
			17'b0100000_101_0110011: rd_val = $signed(rs1_rdata) >>> rs2_rdata[4:0];
			17'b0000000_110_0110011: rd_val = rs1_rdata | rs2_rdata;
			17'b0000000_111_0110011: rd_val = rs1_rdata & rs2_rdata;
			default:                 ill = 1'b1;
		endcase
	end

	assign next_pc = (opc == 7'b1101111) ? pc + imm_j :
	                 (opc == 7'b1100111) ? (rs1_rdata + imm_i) & 32'hffff_fffe :
	                 taken ? pc + imm_b : pc + 32'd4;

	// misaligned target or misaligned word access.
	assign trap = ill || next_pc[1:0] != 2'b00 || ((is_load || is_store) && word && lane != 2'b00);

	always_comb begin
		spec           = '0;
		spec.valid     = 1'b1;
		spec.trap      = trap;
		spec.rs1_addr  = use_rs1 ? insn[19:15] : 5'd0;
		spec.rs2_addr  = use_rs2 ? insn[24:20] : 5'd0;
		spec.rd_addr   = (use_rd && !trap) ? insn[11:7] : 5'd0;
		spec.rd_wdata  = (spec.rd_addr == 5'd0) ? '0 : rd_val;
		spec.pc_wdata  = next_pc;
		spec.mem_addr  = {addr[31:2], 2'b00};
		spec.mem_wdata = st_data;
		if (!trap && is_load)
			spec.mem_rmask = word ? 4'b1111 : 4'b0001 << lane;
		if (!trap && is_store)
			spec.mem_wmask = word ? 4'b1111 : 4'b0001 << lane;
	end

endmodule

// ==== design/rv_step.sv ====
`include "rv_settings.svh"

module rv_step
	import rv_isa_pkg::*, rv_step_pkg::*;
(
	input  logic        run,
	input  logic [31:0] insn,
	input  logic [31:0] pc,
	input  logic [31:0] rdata,
	input  reg_state_t  state,
	output step_out_t   result
);
	insn_fields_t f;
	logic [31:0]  imm_i;
	logic [31:0]  imm_s;
	logic [31:0]  imm_b;
	logic [31:0]  imm_u;
	logic [31:0]  imm_j;
	logic [31:0]  rs1_val;
	logic [31:0]  rs2_val;
	logic [31:0]  pc_plus4;
	alu_op_e      alu_op;
	logic [31:0]  alu_b;
	logic [31:0]  alu_y;
	logic         taken;
	logic [31:0]  ea;
	logic [31:0]  target;
	logic [7:0]   ld_byte;
	logic         legal;
	logic         misaligned;
	logic         trap;
	logic         wr_en;
	logic [31:0]  wr_val;
	mem_req_t     req;

	assign f = insn_fields_t'(insn);

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'd0};
	assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	assign rs1_val  = (f.rs1 == 5'd0) ? '0 : state.x[f.rs1];
	assign rs2_val  = (f.rs2 == 5'd0) ? '0 : state.x[f.rs2];
	assign pc_plus4 = pc + 32'd4;

	//////////////////////////////////////////////////////////////////////
	// alu and branch compare
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_b = (f.opcode == OPC_OP) ? rs2_val : imm_i;
		case (f.funct3)
			3'b000: alu_op = (f.opcode == OPC_OP && f.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001: alu_op = ALU_SLL;
			3'b010: alu_op = ALU_SLT;
			3'b011: alu_op = ALU_SLTU;
			3'b100: alu_op = ALU_XOR;
			3'b101: alu_op = f.funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110: alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
		case (alu_op)
			ALU_ADD:  alu_y = rs1_val + alu_b;
			ALU_SUB:  alu_y = rs1_val - alu_b;
			ALU_SLL:  alu_y = rs1_val << alu_b[4:0];
			ALU_SLT:  alu_y = {31'd0, $signed(rs1_val) < $signed(alu_b)};
			ALU_SLTU: alu_y = {31'd0, rs1_val < alu_b};
			ALU_XOR:  alu_y = rs1_val ^ alu_b;
			ALU_SRL:  alu_y = rs1_val >> alu_b[4:0];
			ALU_SRA:  alu_y = $signed(rs1_val) >>> alu_b[4:0];
			ALU_OR:   alu_y = rs1_val | alu_b;
			default:  alu_y = rs1_val & alu_b;
		endcase
		case (f.funct3)
			3'b000:  taken = (rs1_val == rs2_val);
			3'b001:  taken = (rs1_val != rs2_val);
			3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
			3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
			3'b110:  taken = (rs1_val < rs2_val);
			3'b111:  taken = (rs1_val >= rs2_val);
			default: taken = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// per-opcode effect
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		legal      = 1'b0;
		misaligned = 1'b0;
		wr_en      = 1'b0;
		wr_val     = alu_y;
		target     = pc_plus4;
		ea         = rs1_val + imm_i;
		ld_byte    = '0;
		req        = '0;
		case (f.opcode)
			OPC_LUI, OPC_AUIPC: begin
				legal  = 1'b1;
				wr_en  = 1'b1;
				wr_val = (f.opcode == OPC_LUI) ? imm_u : pc + imm_u;
			end
			OPC_JAL, OPC_JALR: begin
				legal  = (f.opcode == OPC_JAL) || (f.funct3 == 3'b000);
				wr_en  = 1'b1;
				wr_val = pc_plus4;
				target = (f.opcode == OPC_JAL) ? pc + imm_j : ea & ~32'd1;
			end
			OPC_BRANCH: begin
				legal = (f.funct3[2:1] != 2'b01);
				if (taken)
					target = pc + imm_b;
			end
			OPC_LOAD: begin
				legal      = (f.funct3 == 3'b000) || (f.funct3 == 3'b100) || (f.funct3 == 3'b010);
				misaligned = f.funct3[1] && (ea[1:0] != 2'b00);
				wr_en      = 1'b1;
				ld_byte    = rdata[{ea[1:0], 3'b000} +: 8];
				wr_val     = f.funct3[1] ? rdata : {{24{ld_byte[7] & ~f.funct3[2]}}, ld_byte};
				req.addr   = {ea[31:2], 2'b00};
				req.rmask  = f.funct3[1] ? 4'b1111 : 4'b0001 << ea[1:0];
			end
			OPC_STORE: begin
				ea         = rs1_val + imm_s;
				legal      = (f.funct3 == 3'b000) || (f.funct3 == 3'b010);
				misaligned = f.funct3[1] && (ea[1:0] != 2'b00);
				req.addr   = {ea[31:2], 2'b00};
				req.wmask  = f.funct3[1] ? 4'b1111 : 4'b0001 << ea[1:0];
				req.wdata  = f.funct3[1] ? rs2_val : {4{rs2_val[7:0]}};  // byte on every lane.
			end
			OPC_OP_IMM: begin
				wr_en = 1'b1;
				if (f.funct3 == 3'b001)
					legal = (f.funct7 == 7'b0000000);
				else if (f.funct3 == 3'b101)
					legal = ((f.funct7 & 7'b1011111) == 7'b0000000);
				else
					legal = 1'b1;
			end
			OPC_OP: begin
				wr_en = 1'b1;
				legal = (f.funct7 == 7'b0000000) ||
				        (f.funct7 == 7'b0100000 && (f.funct3 == 3'b000 || f.funct3 == 3'b101));
			end
			default: ;
		endcase
		if (target[1:0] != 2'b00)
			misaligned = 1'b1;
	end

	assign trap = !legal || misaligned;

	always_comb begin
		result       = '0;
		result.pc    = target;
		result.regs  = state;
		result.mem   = req;
		result.excep = run && trap;
		if (trap) begin
			result.pc  = `TRAP_VECTOR;
			result.mem = '0;
		end else if (wr_en && f.rd != 5'd0) begin
			result.regs.x[f.rd] = wr_val;
		end
		if (!run) begin
			result.mem.rmask = '0;  // idle bus.
			result.mem.wmask = '0;
		end
	end

endmodule

// ==== design/rv_step_check.sv ====
`include "rv_settings.svh"

module rv_step_check
	import rv_step_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,
	input  spec_t       spec,
	input  step_out_t   result,
	input  reg_state_t  state,
	output logic [31:0] rs1_rdata,
	output logic [31:0] rs2_rdata,
	output logic        mismatch
);
	logic bad;

	// source operands for the spec decoder.
	assign rs1_rdata = (spec.rs1_addr == 5'd0) ? '0 : state.x[spec.rs1_addr];
	assign rs2_rdata = (spec.rs2_addr == 5'd0) ? '0 : state.x[spec.rs2_addr];

	//////////////////////////////////////////////////////////////////////
	// step result against spec
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		bad = 1'b0;
		if (run && spec.valid) begin
			if (spec.trap) begin
				if (result.regs != state || result.pc != `TRAP_VECTOR)
					bad = 1'b1;
				if (result.mem.rmask != 4'd0 || result.mem.wmask != 4'd0 || !result.excep)
					bad = 1'b1;
			end else begin
				for (int i = 1; i <= `NREGS; i++) begin
					if (result.regs.x[i] != ((spec.rd_addr == i) ? spec.rd_wdata : state.x[i]))
						bad = 1'b1;
				end
				if (result.pc != spec.pc_wdata || result.excep)
					bad = 1'b1;
				if (result.mem.rmask != spec.mem_rmask || result.mem.wmask != spec.mem_wmask)
					bad = 1'b1;
				if ((spec.mem_rmask != 4'd0 || spec.mem_wmask != 4'd0) &&
				    result.mem.addr != spec.mem_addr)
					bad = 1'b1;
				for (int k = 0; k < 4; k++) begin
					if (spec.mem_wmask[k] &&
					    result.mem.wdata[8 * k +: 8] != spec.mem_wdata[8 * k +: 8])
						bad = 1'b1;  // only enabled lanes count.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			mismatch <= 1'b0;
		else if (bad)
			mismatch <= 1'b1;  // sticky until reset.
	end

	// both independent models must agree on every retired instruction.
	step_matches_spec: assert property (@(posedge clk) disable iff (!rst_n) run |-> !bad);

endmodule

// ==== design/rv_regs.sv ====
`include "rv_settings.svh"

module rv_regs
	import rv_step_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,
	input  step_out_t   next,
	input  logic [4:0]  dbg_addr,
	output reg_state_t  state,
	output logic [31:0] pc,
	output logic [31:0] instret,
	output logic [31:0] dbg_data
);

	//////////////////////////////////////////////////////////////////////
	// architectural state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= '0;
			pc      <= `RESET_PC;
			instret <= '0;
		end else if (run) begin
			state   <= next.regs;
			pc      <= next.pc;
			instret <= instret + 32'd1;  // one retire per run cycle.
		end
	end

	assign dbg_data = (dbg_addr == 5'd0) ? '0 : state.x[dbg_addr];  // x0 reads zero.

	// relies on the step unit trapping every misaligned target.
	pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// ==== design/rv_hart.sv ====
module rv_hart
	import rv_step_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	output logic [31:0] pc,
	input  logic [31:0] insn,
	output mem_req_t    mem,
	input  logic [31:0] rdata,
	input  logic        run,
	input  logic [4:0]  dbg_addr,
	output logic [31:0] dbg_data,
	output logic [31:0] instret,
	output logic        trap,
	output logic        mismatch
);
	reg_state_t  state;
	step_out_t   result;
	spec_t       spec;
	logic [31:0] rs1_rdata;
	logic [31:0] rs2_rdata;

	rv_regs u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.next     (result),
		.dbg_addr (dbg_addr),
		.state    (state),
		.pc       (pc),
		.instret  (instret),
		.dbg_data (dbg_data)
	);

	rv_step u_step (
		.run    (run),
		.insn   (insn),
		.pc     (pc),
		.rdata  (rdata),
		.state  (state),
		.result (result)
	);

	///////////////////////////////////////////////////////////////////////
	// built-in equivalence check
	///////////////////////////////////////////////////////////////////////

	rv_decode u_decode (
		.insn      (insn),
		.pc        (pc),
		.rdata     (rdata),
		.rs1_rdata (rs1_rdata),
		.rs2_rdata (rs2_rdata),
		.spec      (spec)
	);

	rv_step_check u_check (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.spec      (spec),
		.result    (result),
		.state     (state),
		.rs1_rdata (rs1_rdata),
		.rs2_rdata (rs2_rdata),
		.mismatch  (mismatch)
	);

	assign mem  = result.mem;
	assign trap = result.excep;

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;  // released on a falling edge.
	end

endmodule

// ==== test/tb_rv_hart.sv ====
`include "rv_settings.svh"

module tb_rv_hart
	import rv_step_pkg::*;
();
	localparam int N_ALU    = 400;
	localparam int N_MEM    = 300;
	localparam int N_FLOW   = 300;
	localparam int N_ILL    = 200;
	localparam int N_CYCLES = N_ALU + N_MEM + N_FLOW + N_ILL + 6 * 32 + 20;

	localparam logic [6:0] OP_LUI    = 7'h37;
	localparam logic [6:0] OP_AUIPC  = 7'h17;
	localparam logic [6:0] OP_JAL    = 7'h6f;
	localparam logic [6:0] OP_JALR   = 7'h67;
	localparam logic [6:0] OP_BRANCH = 7'h63;
	localparam logic [6:0] OP_LOAD   = 7'h03;
	localparam logic [6:0] OP_STORE  = 7'h23;
	localparam logic [6:0] OP_IMM    = 7'h13;
	localparam logic [6:0] OP_REG    = 7'h33;

	logic        clk;
	logic        rst_n;
	logic [31:0] pc;
	logic [31:0] insn;
	mem_req_t    mem;
	logic [31:0] rdata;
	logic        run;
	logic [4:0]  dbg_addr;
	logic [31:0] dbg_data;
	logic [31:0] instret;
	logic        trap;
	logic        mismatch;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] model_mem [0:255];
	logic [31:0] xr [0:31];  // model registers with xr[0] held at zero.
	logic [31:0] pc_m;
	logic [31:0] rng;
	int          retired;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	rv_hart uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.pc       (pc),
		.insn     (insn),
		.mem      (mem),
		.rdata    (rdata),
		.run      (run),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data),
		.instret  (instret),
		.trap     (trap),
		.mismatch (mismatch)
	);

	assign insn  = imem[pc[9:2]];
	assign rdata = dmem[mem.addr[9:2]];

	always @(posedge clk) begin
		for (int k = 0; k < 4; k++) begin
			if (mem.wmask[k])
				dmem[mem.addr[9:2]][8 * k +: 8] <= mem.wdata[8 * k +: 8];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checking and random numbers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic draw(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference isa model
	//////////////////////////////////////////////////////////////////////

	function automatic logic is_legal(input logic [31:0] instr);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = instr[14:12];
		f7 = instr[31:25];
		case (instr[6:0])
			OP_LUI, OP_AUIPC, OP_JAL: return 1'b1;
			OP_JALR:   return f3 == 3'b000;
			OP_BRANCH: return f3 != 3'b010 && f3 != 3'b011;
			OP_LOAD:   return f3 == 3'b000 || f3 == 3'b010 || f3 == 3'b100;
			OP_STORE:  return f3 == 3'b000 || f3 == 3'b010;
			OP_IMM: begin
				if (f3 == 3'b001)
					return f7 == 7'h00;
				if (f3 == 3'b101)
					return f7 == 7'h00 || f7 == 7'h20;
				return 1'b1;
			end
			OP_REG:    return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
			default:   return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'b000: return alt ? x - y : x + y;
			3'b001: return x << y[4:0];
			3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b011: return (x < y) ? 32'd1 : 32'd0;
			3'b100: return x ^ y;
			3'b101: begin
				if (alt)
					return $signed(x) >>> y[4:0];  // sign fills from the top.
				return x >> y[4:0];
			end
			3'b110: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'b000: return x == y;
			3'b001: return x != y;
			3'b100: return $signed(x) < $signed(y);
			3'b101: return $signed(x) >= $signed(y);
			3'b110: return x < y;
			default: return x >= y;
		endcase
	endfunction

	// drives one instruction and checks the bus mid-cycle and the state after the edge.
	task automatic run_insn(input logic [31:0] instr, input logic go);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] ea;
		logic [31:0] npc;
		logic [31:0] wval;
		logic [31:0] word;
		logic [7:0]  lane_byte;
		logic        wen;
		logic        bad;
		logic [3:0]  rmask;
		logic [3:0]  wmask;
		opc   = instr[6:0];
		f3    = instr[14:12];
		rd    = instr[11:7];
		a     = xr[instr[19:15]];
		b     = xr[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		ea    = a + imm_i;
		npc   = pc_m + 32'd4;
		bad   = !is_legal(instr);
		wen   = (opc != OP_BRANCH && opc != OP_STORE);
		wval  = pc_m + 32'd4;  // link value of jal and jalr.
		rmask = 4'd0;
		wmask = 4'd0;
		case (opc)
			OP_LUI:    wval = {instr[31:12], 12'd0};
			OP_AUIPC:  wval = pc_m + {instr[31:12], 12'd0};
			OP_JAL:    npc = pc_m + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			OP_JALR:   npc = ea & ~32'd1;
			OP_BRANCH: npc = branch_taken(f3, a, b) ? pc_m + imm_b : npc;
			OP_LOAD: begin
				word  = model_mem[ea[9:2]] >> (8 * ea[1:0]);
				wval  = (f3 == 3'b010) ? model_mem[ea[9:2]] :
				        (f3 == 3'b100) ? {24'd0, word[7:0]} : {{24{word[7]}}, word[7:0]};
				rmask = (f3 == 3'b010) ? 4'hf : 4'h1 << ea[1:0];
			end
			OP_STORE: begin
				ea    = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
				wmask = (f3 == 3'b010) ? 4'hf : 4'h1 << ea[1:0];
			end
			OP_IMM:    wval = alu_result(f3, f3 == 3'b101 && instr[30], a, imm_i);
			OP_REG:    wval = alu_result(f3, instr[30], a, b);
			default: ;
		endcase
		if (npc[1:0] != 2'b00)
			bad = 1'b1;
		if ((opc == OP_LOAD || opc == OP_STORE) && f3 == 3'b010 && ea[1:0] != 2'b00)
			bad = 1'b1;
		if (bad || !go) begin
			rmask = 4'd0;
			wmask = 4'd0;
		end

		imem[pc[9:2]] = instr;
		run           = go;
		dbg_addr      = rd;
		#10;
		check_value("trap", trap, go && bad);
		check_value("mem.rmask", mem.rmask, rmask);
		check_value("mem.wmask", mem.wmask, wmask);
		if (rmask != 4'd0 || wmask != 4'd0)
			check_value("mem.addr", mem.addr, {ea[31:2], 2'b00});
		for (int k = 0; k < 4; k++) begin
			lane_byte = (f3 == 3'b010) ? b[8 * k +: 8] : b[7:0];
			if (wmask[k])
				check_value($sformatf("mem.wdata[%0d]", k), mem.wdata[8 * k +: 8], lane_byte);
		end

		@(negedge clk);
		if (go) begin
			retired++;
			pc_m = bad ? `TRAP_VECTOR : npc;
			if (!bad && wen && rd != 5'd0)
				xr[rd] = wval;
			for (int k = 0; k < 4; k++) begin
				if (wmask[k])
					model_mem[ea[9:2]][8 * k +: 8] = (f3 == 3'b010) ? b[8 * k +: 8] : b[7:0];
			end
		end
		check_value("pc", pc, pc_m);
		check_value($sformatf("x%0d", rd), dbg_data, xr[rd]);
		check_value("instret", instret, retired);
		check_value("mismatch", mismatch, 1'b0);
		check_value("data memory word", dmem[ea[9:2]], model_mem[ea[9:2]]);
	endtask

	// idle cycles that read every register on the debug port.
	task automatic sweep_regs();
		run = 1'b0;
		for (int i = 0; i < 32; i++) begin
			dbg_addr = 5'(i);
			#10;
			check_value($sformatf("x%0d", i), dbg_data, xr[i]);
			check_value("mem.rmask", mem.rmask, 4'd0);
			check_value("mem.wmask", mem.wmask, 4'd0);
			@(negedge clk);
		end
		check_value("pc", pc, pc_m);
		check_value("instret", instret, retired);
	endtask

	//////////////////////////////////////////////////////////////////////
	// random instruction makers
	//////////////////////////////////////////////////////////////////////

	task automatic make_insn(input int kind, output logic [31:0] instr);
		logic [31:0] s;
		logic [31:0] t;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  rs1;
		logic [20:0] off;
		draw(s);
		draw(t);
		f3  = t[14:12];
		rs1 = s[7] ? 5'd0 : t[19:15];  // x0 base keeps many addresses aligned.
		off = {t[31:12], 1'b0};
		if (s[5])
			off[1] = 1'b0;
		case (kind)
			0: begin
				if (s[1:0] == 2'd0)
					instr = {t[31:12], t[11:7], s[2] ? OP_LUI : OP_AUIPC};
				else if (s[1:0] == 2'd3)
					instr = {(f3 == 3'b000 || f3 == 3'b101) ? {1'b0, s[3], 5'd0} : 7'd0,
					         t[24:20], t[19:15], f3, t[11:7], OP_REG};
				else begin
					f7    = (f3 == 3'b001) ? 7'd0 : (f3 == 3'b101) ? {1'b0, s[3], 5'd0} : t[31:25];
					instr = {f7, t[24:20], t[19:15], f3, t[11:7], OP_IMM};
				end
			end
			1: begin
				if (s[1:0] == 2'd3)
					instr = {off[11:5], t[24:20], rs1, s[2] ? 3'b010 : 3'b000, off[4:0], OP_STORE};
				else
					instr = {off[11:0], rs1, (s[1:0] == 2'd0) ? 3'b000 : (s[0] ? 3'b100 : 3'b010),
					         t[11:7], OP_LOAD};
			end
			2: begin
				f3 = (s[4:2] < 3'd2) ? s[4:2] : (s[4:2] < 3'd6) ? s[4:2] + 3'd2 : 3'b111;
				if (s[1:0] < 2'd2)
					instr = {off[12], off[10:5], s[6] ? rs1 : t[24:20], rs1, f3, off[4:1], off[11],
					         OP_BRANCH};
				else if (s[1:0] == 2'd2)
					instr = {off[20], off[10:1], off[11], off[19:12], t[11:7], OP_JAL};
				else
					instr = {off[11:0], rs1, 3'b000, t[11:7], OP_JALR};
			end
			default: begin
				instr = t;
				while (is_legal(instr))
					draw(instr);
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] instr;
		logic [31:0] s;
		run      = 1'b0;
		dbg_addr = 5'd0;
		rng      = 32'd38;
		pc_m     = `RESET_PC;
		retired  = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i]      = 32'h0000_0013;  // addi x0, x0, 0.
			dmem[i]      = (i + 1) * 32'h9e37_79b9;
			model_mem[i] = (i + 1) * 32'h9e37_79b9;
		end
		for (int i = 0; i < 32; i++)
			xr[i] = 32'd0;

		wait (rst_n === 1'b1);
		check_value("pc", pc, `RESET_PC);
		check_value("instret", instret, 32'd0);
		check_value("mismatch", mismatch, 1'b0);
		sweep_regs();

		for (int kind = 0; kind < 4; kind++) begin
			repeat (kind == 0 ? N_ALU : kind == 1 ? N_MEM : kind == 2 ? N_FLOW : N_ILL) begin
				make_insn(kind, instr);
				draw(s);
				run_insn(instr, s[2:0] != 3'd0);  // about one idle cycle in eight.
			end
			sweep_regs();
		end

		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		#(N_CYCLES * 40 + 4000);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== all.f ====
+incdir+include
design/rv_isa_pkg.sv
design/rv_step_pkg.sv
design/rv_decode.sv
design/rv_step.sv
design/rv_step_check.sv
design/rv_regs.sv
design/rv_hart.sv
test/tb_clock.sv
test/tb_rv_hart.sv
